/* common/neuron_consts.svh */
`ifndef NEURON_CONSTS_SVH
`define NEURON_CONSTS_SVH

`define NODE_INPUTS 10
`define NODE_HALF 5
`define NODE_DATA_W 8
`define NODE_FRAC 6
`define NODE_PROD_W 16
`define NODE_PSUM_W 19
`define NODE_SUM_W 23
`define NODE_LATENCY 4

`define AXI_ADDR_W 8

`define REG_CTRL 8'h00
`define REG_BIAS 8'h04
`define REG_RESULT 8'h08
`define REG_ACT0 8'h10
`define REG_WGT0 8'h20

`endif

/* common/neuron_pkg.sv */
`include "neuron_consts.svh"

package neuron_pkg;

	// All operands are Q1.6 fixed point
	typedef logic signed [`NODE_DATA_W-1:0] operand_t;

	typedef operand_t [`NODE_HALF-1:0] operand_half_t;

	typedef logic signed [`NODE_PSUM_W-1:0] psum_t;

	typedef struct packed
	{
		logic [29:0] reserved;
		logic clear_done;
		logic start;
	} ctrl_fields_t;

	// A bus word is either four operand bytes or the control fields
	typedef union packed
	{
		operand_t [3:0] lanes; // Lane 0 sits in bits 7:0
		ctrl_fields_t ctrl;
	} reg_word_u;

	typedef enum logic [1:0]
	{
		OKAY = 2'b00,
		SLVERR = 2'b10
	} axi_resp_t;

endpackage

/* common/node_operand_if.sv */
`timescale 1ns/1ps

interface node_operand_if;

	logic issue; // One cycle pulse, operands valid with it
	neuron_pkg::operand_half_t a_lo;
	neuron_pkg::operand_half_t a_hi;
	neuron_pkg::operand_half_t w_lo;
	neuron_pkg::operand_half_t w_hi;
	neuron_pkg::operand_t bias;

	modport source
	(
		output issue,
		output a_lo,
		output a_hi,
		output w_lo,
		output w_hi,
		output bias
	);

	modport sink
	(
		input issue,
		input a_lo,
		input a_hi,
		input w_lo,
		input w_hi,
		input bias
	);

endinterface

/* node_regs/node_axi_regs.sv */
`timescale 1ns/1ps
`include "neuron_consts.svh"

module node_axi_regs
(
	input logic clk,
	input logic reset,
	input logic [`AXI_ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output neuron_pkg::axi_resp_t bresp,
	output logic bvalid,
	input logic bready,
	input logic [`AXI_ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output neuron_pkg::axi_resp_t rresp,
	output logic rvalid,
	input logic rready,
	node_operand_if.source op,
	input neuron_pkg::operand_t result,
	input logic result_valid
);

	logic aw_full;
	logic w_full;
	logic [`AXI_ADDR_W-1:0] addr_q;
	neuron_pkg::reg_word_u wr_word;
	logic [3:0] strb_q;
	logic aw_hs;
	logic w_hs;
	logic ar_hs;
	logic wr_fire;
	logic aw_full_n;
	logic w_full_n;
	logic bvalid_n;
	logic rvalid_n;
	logic [1:0] wr_act_word;
	logic [1:0] wr_wgt_word;
	logic [1:0] rd_act_word;
	logic [1:0] rd_wgt_word;
	logic wr_ctrl;
	logic wr_bias;
	logic wr_mapped;
	logic start;
	logic clear;
	logic rd_mapped;
	neuron_pkg::reg_word_u rd_word;
	neuron_pkg::operand_t act [`NODE_INPUTS];
	neuron_pkg::operand_t wgt [`NODE_INPUTS];
	neuron_pkg::operand_t bias_r;
	neuron_pkg::operand_t result_r;
	logic done;
	logic busy;
	logic [$clog2(`NODE_LATENCY+1)-1:0] inflight;

	// Word 0 to 2 of an operand block, 3 when the address is outside it
	function automatic logic [1:0] operand_word(input logic [`AXI_ADDR_W-1:0] addr,
		input logic [`AXI_ADDR_W-1:0] base);
		if (addr[1:0] == 2'b00 && addr >= base && addr < base + 8'd12)
			return addr[3:2];
		return 2'd3;
	endfunction

	assign aw_hs = awvalid && awready;
	assign w_hs = wvalid && wready;
	assign ar_hs = arvalid && arready;
	assign wr_fire = aw_full && w_full;

	assign aw_full_n = (aw_full && !wr_fire) || aw_hs;
	assign w_full_n = (w_full && !wr_fire) || w_hs;
	assign bvalid_n = wr_fire || (bvalid && !bready);
	assign rvalid_n = ar_hs || (rvalid && !rready);

	assign wr_act_word = operand_word(addr_q, `REG_ACT0);
	assign wr_wgt_word = operand_word(addr_q, `REG_WGT0);
	assign wr_ctrl = addr_q == `REG_CTRL;
	assign wr_bias = addr_q == `REG_BIAS;
	assign wr_mapped = wr_ctrl || wr_bias || addr_q == `REG_RESULT
		|| wr_act_word != 2'd3 || wr_wgt_word != 2'd3;

	assign start = wr_fire && wr_ctrl && strb_q[0] && wr_word.ctrl.start;
	assign clear = wr_fire && wr_ctrl && strb_q[0] && (wr_word.ctrl.clear_done || wr_word.ctrl.start);

	assign op.issue = start;
	assign op.bias = bias_r;
	assign busy = inflight != '0;

	always_comb
	begin
		for (int i = 0; i < `NODE_HALF; i++)
		begin
			op.a_lo[i] = act[i];
			op.a_hi[i] = act[i + `NODE_HALF];
			op.w_lo[i] = wgt[i];
			op.w_hi[i] = wgt[i + `NODE_HALF];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			aw_full <= 1'b0;
			w_full <= 1'b0;
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= neuron_pkg::OKAY;
		end
		else
		begin
			aw_full <= aw_full_n;
			w_full <= w_full_n;
			bvalid <= bvalid_n;
			awready <= !aw_full_n && !bvalid_n; // Held low while a response waits
			wready <= !w_full_n && !bvalid_n;
			if (wr_fire)
				bresp <= wr_mapped ? neuron_pkg::OKAY : neuron_pkg::SLVERR;
		end
	end

	always_ff @(posedge clk)
	begin
		if (aw_hs)
			addr_q <= awaddr;
		if (w_hs)
		begin
			wr_word <= wdata;
			strb_q <= wstrb;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `NODE_INPUTS; i++)
			begin
				act[i] <= '0;
				wgt[i] <= '0;
			end
			bias_r <= '0;
		end
		else if (wr_fire)
		begin
			if (wr_bias && strb_q[0])
				bias_r <= wr_word.lanes[0];
			for (int l = 0; l < 4; l++)
			begin
				if (wr_act_word != 2'd3 && strb_q[l] && {wr_act_word, 2'b00} + l < `NODE_INPUTS)
					act[{wr_act_word, 2'b00} + l] <= wr_word.lanes[l];
				if (wr_wgt_word != 2'd3 && strb_q[l] && {wr_wgt_word, 2'b00} + l < `NODE_INPUTS)
					wgt[{wr_wgt_word, 2'b00} + l] <= wr_word.lanes[l];
			end
		end
	end

	// Status and result capture
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			done <= 1'b0;
			result_r <= '0;
			inflight <= '0;
		end
		else
		begin
			if (clear)
				done <= 1'b0;
			if (result_valid)
			begin
				done <= 1'b1; // A fresh result wins over a clear in the same cycle
				result_r <= result;
			end
			case ({start, result_valid})
				2'b10: inflight <= inflight + 1'b1;
				2'b01: inflight <= inflight - 1'b1;
				default: inflight <= inflight;
			endcase
		end
	end

	assign rd_act_word = operand_word(araddr, `REG_ACT0);
	assign rd_wgt_word = operand_word(araddr, `REG_WGT0);

	always_comb
	begin
		rd_word = '0;
		rd_mapped = 1'b1;
		if (araddr == `REG_CTRL)
			rd_word = {30'b0, busy, done};
		else if (araddr == `REG_BIAS)
			rd_word.lanes[0] = bias_r;
		else if (araddr == `REG_RESULT)
			rd_word.lanes[0] = result_r;
		else if (rd_act_word != 2'd3)
		begin
			for (int l = 0; l < 4; l++)
				if ({rd_act_word, 2'b00} + l < `NODE_INPUTS)
					rd_word.lanes[l] = act[{rd_act_word, 2'b00} + l];
		end
		else if (rd_wgt_word != 2'd3)
		begin
			for (int l = 0; l < 4; l++)
				if ({rd_wgt_word, 2'b00} + l < `NODE_INPUTS)
					rd_word.lanes[l] = wgt[{rd_wgt_word, 2'b00} + l];
		end
		else
			rd_mapped = 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
			rresp <= neuron_pkg::OKAY;
		end
		else
		begin
			rvalid <= rvalid_n;
			arready <= !rvalid_n;
			if (ar_hs)
			begin
				rdata <= rd_word;
				rresp <= rd_mapped ? neuron_pkg::OKAY : neuron_pkg::SLVERR;
			end
		end
	end

endmodule

/* logic/partial_dot.sv */
`timescale 1ns/1ps
`include "neuron_consts.svh"

module partial_dot
(
	input logic clk,
	input logic reset,
	input logic issue,
	input neuron_pkg::operand_half_t a,
	input neuron_pkg::operand_half_t w,
	output neuron_pkg::psum_t psum
);

	logic signed [`NODE_PROD_W-1:0] prod [`NODE_HALF]; // Q2.12 products
	logic prod_valid;
	neuron_pkg::psum_t prod_sum;

	always_comb
	begin
		prod_sum = '0;
		for (int i = 0; i < `NODE_HALF; i++)
			prod_sum = prod_sum + prod[i];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			prod_valid <= 1'b0;
			for (int i = 0; i < `NODE_HALF; i++)
				prod[i] <= '0;
			psum <= '0;
		end
		else
		begin
			prod_valid <= issue;
			if (issue)
			begin
				for (int i = 0; i < `NODE_HALF; i++)
					prod[i] <= $signed(a[i]) * $signed(w[i]);
			end
			if (prod_valid)
				psum <= prod_sum;
		end
	end

endmodule

/* logic/node_combine.sv */
`timescale 1ns/1ps
`include "neuron_consts.svh"

module node_combine
(
	input logic clk,
	input logic reset,
	node_operand_if.sink op,
	input neuron_pkg::psum_t psum_lo,
	input neuron_pkg::psum_t psum_hi,
	output neuron_pkg::operand_t result,
	output logic result_valid
);

	neuron_pkg::operand_t bias_d1;
	neuron_pkg::operand_t bias_d2;
	logic issue_d1;
	logic issue_d2;
	logic sum_valid;
	logic signed [`NODE_SUM_W-1:0] bias_ext;
	logic signed [`NODE_SUM_W-1:0] sum;
	logic [`NODE_SUM_W-`NODE_FRAC-1:0] rounded;
	logic overflow;

	// Bias moves to the product scale of 12 fraction bits
	assign bias_ext = {{(`NODE_SUM_W - `NODE_DATA_W - `NODE_FRAC){bias_d2[`NODE_DATA_W-1]}},
		bias_d2, {`NODE_FRAC{1'b0}}};

	assign rounded = sum[`NODE_SUM_W-1:`NODE_FRAC] + sum[`NODE_FRAC-1];

	// Every bit above the result byte has to repeat the sign
	assign overflow = rounded[`NODE_SUM_W-`NODE_FRAC-1:`NODE_DATA_W-1]
		!= {(`NODE_SUM_W - `NODE_FRAC - `NODE_DATA_W + 1){rounded[`NODE_SUM_W-`NODE_FRAC-1]}};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			issue_d1 <= 1'b0;
			issue_d2 <= 1'b0;
			sum_valid <= 1'b0;
			result_valid <= 1'b0;
			bias_d1 <= '0;
			bias_d2 <= '0;
			sum <= '0;
			result <= '0;
		end
		else
		begin
			issue_d1 <= op.issue;
			issue_d2 <= issue_d1;
			sum_valid <= issue_d2;
			result_valid <= sum_valid;
			bias_d1 <= op.bias;
			bias_d2 <= bias_d1;
			if (issue_d2)
				sum <= psum_lo + psum_hi + bias_ext; // Lines up with both psums
			if (sum_valid)
			begin
				if (overflow)
					result <= rounded[`NODE_SUM_W-`NODE_FRAC-1] ? 8'sh80 : 8'sh7f;
				else
					result <= rounded[`NODE_DATA_W-1:0];
			end
		end
	end

endmodule

/* logic/node_top.sv */
`timescale 1ns/1ps
`include "neuron_consts.svh"

module node_top
(
	input logic clk,
	input logic reset,
	input logic [`AXI_ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [`AXI_ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	node_operand_if op_if();

	neuron_pkg::psum_t psum_lo;
	neuron_pkg::psum_t psum_hi;
	neuron_pkg::operand_t result;
	logic result_valid;

	node_axi_regs regs
	(
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.op(op_if.source),
		.result(result),
		.result_valid(result_valid)
	);

	partial_dot dot_lo
	(
		.clk(clk),
		.reset(reset),
		.issue(op_if.issue),
		.a(op_if.a_lo),
		.w(op_if.w_lo),
		.psum(psum_lo)
	);

	partial_dot dot_hi
	(
		.clk(clk),
		.reset(reset),
		.issue(op_if.issue),
		.a(op_if.a_hi),
		.w(op_if.w_hi),
		.psum(psum_hi)
	);

	node_combine combine
	(
		.clk(clk),
		.reset(reset),
		.op(op_if.sink),
		.psum_lo(psum_lo),
		.psum_hi(psum_hi),
		.result(result),
		.result_valid(result_valid)
	);

endmodule

/* tb/node_checker.sv */
`timescale 1ns/1ps
`include "neuron_consts.svh"

module node_checker
(
	input logic clk,
	input logic reset,
	input logic [`AXI_ADDR_W-1:0] awaddr,
	input logic awvalid,
	input logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	input logic wready,
	input logic [1:0] bresp,
	input logic bvalid,
	input logic bready,
	input logic [`AXI_ADDR_W-1:0] araddr,
	input logic arvalid,
	input logic arready,
	input logic [31:0] rdata,
	input logic [1:0] rresp,
	input logic rvalid,
	input logic rready
);

	int errors = 0;
	int checks = 0;
	logic signed [7:0] act_s [`NODE_INPUTS];
	logic signed [7:0] wgt_s [`NODE_INPUTS];
	logic signed [7:0] bias_s;
	logic signed [7:0] result_exp;
	logic [`AXI_ADDR_W-1:0] aw_q;
	logic [`AXI_ADDR_W-1:0] ar_q;
	logic [31:0] wd_q;
	logic [3:0] ws_q;
	logic quiet; // Nothing in flight, so CTRL and RESULT are predictable
	logic done_exp;

	function automatic logic mapped(input logic [`AXI_ADDR_W-1:0] addr);
		if (addr == `REG_CTRL || addr == `REG_BIAS || addr == `REG_RESULT)
			return 1'b1;
		if (addr[1:0] != 2'b00)
			return 1'b0;
		return (addr >= `REG_ACT0 && addr < `REG_ACT0 + 12)
			|| (addr >= `REG_WGT0 && addr < `REG_WGT0 + 12);
	endfunction

	// Full-width sum, round half up, then clamp to the byte range
	function automatic logic signed [7:0] neuron_ref();
		int acc;
		int r;
		acc = int'(bias_s) * 64;
		for (int i = 0; i < `NODE_INPUTS; i++)
			acc += int'(act_s[i]) * int'(wgt_s[i]);
		r = (acc + 32) >>> 6;
		if (r > 127)
			r = 127;
		else if (r < -128)
			r = -128;
		return r[7:0];
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("[FAIL] %0t ns %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
		end
	endtask

	task automatic apply_write();
		int idx;
		compare("bresp", mapped(aw_q) ? neuron_pkg::OKAY : neuron_pkg::SLVERR, bresp);
		if (aw_q == `REG_CTRL && ws_q[0])
		begin
			if (wd_q[0])
			begin
				result_exp = neuron_ref(); // Operands are taken at the start
				quiet = 1'b0;
			end
			if (wd_q[0] || wd_q[1])
				done_exp = 1'b0;
		end
		else if (aw_q == `REG_BIAS && ws_q[0])
			bias_s = wd_q[7:0];
		else if (mapped(aw_q) && aw_q >= `REG_ACT0)
		begin
			for (int l = 0; l < 4; l++)
			begin
				idx = 4 * aw_q[3:2] + l;
				if (ws_q[l] && idx < `NODE_INPUTS && aw_q >= `REG_WGT0)
					wgt_s[idx] = wd_q[8*l +: 8];
				else if (ws_q[l] && idx < `NODE_INPUTS)
					act_s[idx] = wd_q[8*l +: 8];
			end
		end
	endtask

	task automatic check_read();
		logic [31:0] expected;
		int idx;
		expected = '0;
		compare("rresp", mapped(ar_q) ? neuron_pkg::OKAY : neuron_pkg::SLVERR, rresp);
		if (ar_q == `REG_CTRL)
		begin
			if (quiet)
				compare("rdata CTRL", {30'b0, 1'b0, done_exp}, rdata);
			else if (!rdata[1])
			begin
				// Busy just dropped, so the last result must have landed
				compare("rdata CTRL done", 32'd1, {31'b0, rdata[0]});
				quiet = 1'b1;
				done_exp = 1'b1;
			end
			return;
		end
		if (ar_q == `REG_RESULT && !quiet)
			return;
		if (ar_q == `REG_BIAS)
			expected[7:0] = bias_s;
		else if (ar_q == `REG_RESULT)
			expected[7:0] = result_exp;
		else if (mapped(ar_q))
		begin
			for (int l = 0; l < 4; l++)
			begin
				idx = 4 * ar_q[3:2] + l;
				if (idx < `NODE_INPUTS)
					expected[8*l +: 8] = (ar_q >= `REG_WGT0) ? wgt_s[idx] : act_s[idx];
			end
		end
		compare($sformatf("rdata at 0x%02h", ar_q), expected, rdata);
	endtask

	always @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `NODE_INPUTS; i++)
			begin
				act_s[i] = '0;
				wgt_s[i] = '0;
			end
			bias_s = '0;
			result_exp = '0;
			quiet = 1'b1;
			done_exp = 1'b0;
		end
		else
		begin
			if (bvalid && bready)
				apply_write();
			if (rvalid && rready)
				check_read();
			if (awvalid && awready)
				aw_q = awaddr;
			if (wvalid && wready)
			begin
				wd_q = wdata;
				ws_q = wstrb;
			end
			if (arvalid && arready)
				ar_q = araddr;
		end
	end

endmodule

/* tb/node_tb.sv */
`timescale 1ns/1ps
`include "neuron_consts.svh"

module node_tb;

	localparam int WAIT_LIMIT = 20;
	localparam int POLL_LIMIT = 40;

	logic clk;
	logic reset;
	logic [`AXI_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`AXI_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	logic signed [7:0] act_v [`NODE_INPUTS];
	logic signed [7:0] wgt_v [`NODE_INPUTS];
	logic signed [7:0] bias_v;
	logic [7:0] rw_addrs [7] = '{`REG_BIAS, 8'h10, 8'h14, 8'h18, 8'h20, 8'h24, 8'h28};
	logic [7:0] bad_addrs [8] = '{8'h0c, 8'h1c, 8'h2c, 8'h30, 8'h40, 8'hfc, 8'h11, 8'h06};
	int hangs = 0;
	int reported = 0;

	node_top uut
	(
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

	node_checker chk
	(
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Tasks are entered 1 ns after a rising edge, where every DUT output is stable
	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int n;
		logic aw_now;
		logic w_now;
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		n = 0;
		while ((awvalid || wvalid) && n < WAIT_LIMIT)
		begin
			aw_now = awvalid && awready;
			w_now = wvalid && wready;
			@(posedge clk);
			#1;
			if (aw_now)
				awvalid = 1'b0;
			if (w_now)
				wvalid = 1'b0;
			n++;
		end
		if (awvalid || wvalid)
		begin
			$display("Write to 0x%02h was never accepted by the DUT", addr);
			hangs++;
			awvalid = 1'b0;
			wvalid = 1'b0;
			return;
		end
		bready = 1'b1;
		n = 0;
		while (!bvalid && n < WAIT_LIMIT)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (bvalid)
		begin
			@(posedge clk);
			#1;
		end
		else
		begin
			$display("Write to 0x%02h never got a write response", addr);
			hangs++;
		end
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
		int n;
		data = '0;
		araddr = addr;
		arvalid = 1'b1;
		n = 0;
		while (!arready && n < WAIT_LIMIT)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!arready)
		begin
			$display("Read of 0x%02h was never accepted by the DUT", addr);
			hangs++;
			arvalid = 1'b0;
			return;
		end
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		rready = 1'b1;
		n = 0;
		while (!rvalid && n < WAIT_LIMIT)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (rvalid)
		begin
			data = rdata;
			@(posedge clk);
			#1;
		end
		else
		begin
			$display("Read of 0x%02h never returned data", addr);
			hangs++;
		end
		rready = 1'b0;
	endtask

	function automatic logic [31:0] pack_word(input logic wgt_side, input int k);
		logic [31:0] word;
		word = '0;
		for (int l = 0; l < 4; l++)
			if (4 * k + l < `NODE_INPUTS)
				word[8*l +: 8] = wgt_side ? wgt_v[4*k+l] : act_v[4*k+l];
		return word;
	endfunction

	task automatic random_operands(input int mag);
		for (int i = 0; i < `NODE_INPUTS; i++)
		begin
			act_v[i] = $urandom % (2 * mag + 1) - mag;
			wgt_v[i] = $urandom % (2 * mag + 1) - mag;
		end
		bias_v = $urandom % (2 * mag + 1) - mag;
	endtask

	task automatic fill_operands(input logic signed [7:0] a, input logic signed [7:0] w,
		input logic signed [7:0] b);
		for (int i = 0; i < `NODE_INPUTS; i++)
		begin
			act_v[i] = a;
			wgt_v[i] = w;
		end
		bias_v = b;
	endtask

	task automatic write_operands();
		axi_write(`REG_BIAS, {24'b0, bias_v}, 4'h1);
		for (int k = 0; k < 3; k++)
		begin
			axi_write(`REG_ACT0 + 4 * k, pack_word(1'b0, k), 4'hf);
			axi_write(`REG_WGT0 + 4 * k, pack_word(1'b1, k), 4'hf);
		end
	endtask

	// Polls until done is set and nothing is left in flight
	task automatic wait_done();
		logic [31:0] status;
		int n;
		status = '0;
		n = 0;
		while (!(status[0] && !status[1]) && n < POLL_LIMIT)
		begin
			axi_read(`REG_CTRL, status);
			n++;
		end
		if (!(status[0] && !status[1]))
		begin
			$display("Done flag never came up while polling CTRL");
			hangs++;
		end
	endtask

	task automatic compute_and_read();
		logic [31:0] res;
		write_operands();
		axi_write(`REG_CTRL, 32'h1, 4'h1);
		wait_done();
		axi_read(`REG_RESULT, res);
	endtask

	task automatic finish_test(input string name);
		int total;
		total = chk.errors + hangs;
		$display("%s: %0d errors", name, total - reported);
		reported = total;
	endtask

	initial
	begin
		logic [31:0] rd;
		logic [7:0] addr;
		rd = $urandom(32'ha6d7);
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		@(posedge clk);
		#1;

		axi_read(`REG_CTRL, rd);
		repeat (30)
		begin
			addr = rw_addrs[$urandom % 7];
			axi_write(addr, $urandom, $urandom % 16);
			axi_read(addr, rd);
		end
		finish_test("Register readback");

		repeat (40)
		begin
			random_operands(16);
			compute_and_read();
		end
		finish_test("Random dot products");

		fill_operands(127, 127, 127);
		compute_and_read();
		fill_operands(127, -128, -128);
		compute_and_read();
		fill_operands(0, 0, 127);
		act_v[0] = 32; // Adds half an LSB on top of 127
		wgt_v[0] = 1;
		compute_and_read();
		finish_test("Saturation");

		for (int i = 0; i < 4; i++)
		begin
			fill_operands(0, 0, (i < 2) ? 5 : -5);
			act_v[0] = (i % 2 == 0) ? 32 : 31;
			wgt_v[0] = 1;
			compute_and_read();
		end
		finish_test("Rounding");

		random_operands(20);
		write_operands();
		axi_write(`REG_CTRL, 32'h1, 4'h1);
		bias_v = bias_v + 8'sd40; // Second result sits 40 steps away from the first
		axi_write(`REG_BIAS, {24'b0, bias_v}, 4'h1);
		axi_write(`REG_CTRL, 32'h1, 4'h1);
		wgt_v[5] = -wgt_v[5] - 8'sd1; // Lands while the second item is in flight
		axi_write(`REG_WGT0 + 4, pack_word(1'b1, 1), 4'hf);
		wait_done();
		axi_read(`REG_RESULT, rd);
		axi_write(`REG_CTRL, 32'h2, 4'h1);
		axi_read(`REG_CTRL, rd);
		finish_test("Pipelining and snapshot");

		foreach (bad_addrs[i])
		begin
			axi_write(bad_addrs[i], $urandom, 4'hf);
			axi_read(bad_addrs[i], rd);
		end
		foreach (rw_addrs[i])
			axi_read(rw_addrs[i], rd);
		finish_test("Decode errors");

		$display("Checks %0d, errors %0d", chk.checks, chk.errors + hangs);
		if (chk.errors + hangs == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* tb.f */
+incdir+common
common/neuron_pkg.sv
common/node_operand_if.sv
node_regs/node_axi_regs.sv
logic/partial_dot.sv
logic/node_combine.sv
logic/node_top.sv
tb/node_checker.sv
tb/node_tb.sv
